// File: Bender.yml
package:
  name: frontend

export_include_dirs:
  - design

sources:
  - design/core_pkg.sv
  - design/bpu_pkg.sv
  - design/pc_gen_stage.sv
  - design/bht.sv
  - design/btb.sv
  - design/branch_predictor.sv
  - design/frontend_top.sv
  - target: test
    files:
      - test/tb_frontend.sv

// File: design/bht.sv
`timescale 1ns/1ps

`include "frontend_defs.svh"

module bht
  import bpu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  bht_idx_t   rd_idx_i,
  output bht_state_t rd_state_o,
  input  logic       wr_en_i,
  input  bht_idx_t   wr_idx_i,
  input  logic       wr_taken_i
);

  // Counter array
  bht_state_t cnt_q [`BHT_ENTRIES];

  // Stepped value of the counter being trained
  bht_state_t cnt_upd;

  // Lookup is purely combinational
  // A write in the same cycle lands only at the edge
  assign rd_state_o = cnt_q[rd_idx_i];

  // Saturating step toward the actual outcome
  always_comb begin
    cnt_upd = cnt_q[wr_idx_i];
    if (wr_taken_i) begin
      case (cnt_q[wr_idx_i])
        STRONG_NT: cnt_upd = WEAK_NT;
        WEAK_NT:   cnt_upd = WEAK_T;
        WEAK_T:    cnt_upd = STRONG_T;
        default:   cnt_upd = STRONG_T;
      endcase
    end else begin
      case (cnt_q[wr_idx_i])
        STRONG_T: cnt_upd = WEAK_T;
        WEAK_T:   cnt_upd = WEAK_NT;
        WEAK_NT:  cnt_upd = STRONG_NT;
        default:  cnt_upd = STRONG_NT;
      endcase
    end
  end

  // Every counter starts weakly not-taken
  // so one taken outcome is enough to flip the prediction
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `BHT_ENTRIES; i++) begin
        cnt_q[i] <= WEAK_NT;
      end
    end else if (wr_en_i) begin
      cnt_q[wr_idx_i] <= cnt_upd;
    end
  end

endmodule

// File: design/bpu_pkg.sv
`include "frontend_defs.svh"

package bpu_pkg;

  import core_pkg::*;

  // Index widths derived from the table depths
  localparam int unsigned BHT_IDX_W = $clog2(`BHT_ENTRIES);
  localparam int unsigned BTB_IDX_W = $clog2(`BTB_ENTRIES);

  // Tag keeps every PC bit above the BTB index
  localparam int unsigned BTB_TAG_W = `XLEN - BTB_IDX_W - PC_ALIGN_BITS;

  typedef logic [BHT_IDX_W-1:0] bht_idx_t;
  typedef logic [BTB_IDX_W-1:0] btb_idx_t;
  typedef logic [BTB_TAG_W-1:0] btb_tag_t;

  // Two-bit saturating counter
  // MSB set means the branch is predicted taken
  typedef enum logic [1:0] {
    STRONG_NT = 2'b00,
    WEAK_NT   = 2'b01,
    WEAK_T    = 2'b10,
    STRONG_T  = 2'b11
  } bht_state_t;

  // Prediction handed to the PC stage
  typedef struct packed {
    logic taken;
    pc_t  target;
  } prediction_t;

  // Resolution report from execute
  // valid is a one-cycle pulse per resolved branch
  // taken and target are the actual outcome, not the predicted one
  typedef struct packed {
    logic valid;
    logic mispredict;
    logic taken;
    pc_t  pc;
    pc_t  target;
  } resolution_t;

endpackage

// File: design/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor
  import core_pkg::*;
  import bpu_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  pc_t         pc_i,
  input  resolution_t res_i,
  output prediction_t pred_o
);

  bht_idx_t   lookup_idx;
  bht_idx_t   train_idx;
  bht_state_t bht_state;
  logic       btb_hit;
  pc_t        btb_target;
  logic       dir_taken;
  logic       btb_wr_en;

  // BHT index from the lookup PC and from the resolved branch
  assign lookup_idx = pc_i[BHT_IDX_W+PC_ALIGN_BITS-1:PC_ALIGN_BITS];
  assign train_idx  = res_i.pc[BHT_IDX_W+PC_ALIGN_BITS-1:PC_ALIGN_BITS];

  // Only taken branches claim a BTB entry
  assign btb_wr_en = res_i.valid && res_i.taken;

  // Direction table
  // Trained on every resolved branch, taken or not
  bht i_bht (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rd_idx_i   (lookup_idx),
    .rd_state_o (bht_state),
    .wr_en_i    (res_i.valid),
    .wr_idx_i   (train_idx),
    .wr_taken_i (res_i.taken)
  );

  // Target buffer
  btb i_btb (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rd_pc_i     (pc_i),
    .hit_o       (btb_hit),
    .rd_target_o (btb_target),
    .wr_en_i     (btb_wr_en),
    .wr_pc_i     (res_i.pc),
    .wr_target_i (res_i.target)
  );

  // Counter in one of the two taken states
  assign dir_taken = (bht_state == WEAK_T) || (bht_state == STRONG_T);

  // Taken needs both a leaning counter and a known target
  assign pred_o.taken  = btb_hit && dir_taken;
  assign pred_o.target = btb_target;

endmodule

// File: design/btb.sv
`timescale 1ns/1ps

`include "frontend_defs.svh"

module btb
  import core_pkg::*;
  import bpu_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  pc_t  rd_pc_i,
  output logic hit_o,
  output pc_t  rd_target_o,
  input  logic wr_en_i,
  input  pc_t  wr_pc_i,
  input  pc_t  wr_target_i
);

  // Per-entry storage
  logic     valid_q  [`BTB_ENTRIES];
  btb_tag_t tag_q    [`BTB_ENTRIES];
  pc_t      target_q [`BTB_ENTRIES];

  btb_idx_t rd_idx;
  btb_tag_t rd_tag;
  btb_idx_t wr_idx;
  btb_tag_t wr_tag;

  // Index sits right above the alignment bits, tag is everything above it
  assign rd_idx = rd_pc_i[BTB_IDX_W+PC_ALIGN_BITS-1:PC_ALIGN_BITS];
  assign rd_tag = rd_pc_i[`XLEN-1:BTB_IDX_W+PC_ALIGN_BITS];
  assign wr_idx = wr_pc_i[BTB_IDX_W+PC_ALIGN_BITS-1:PC_ALIGN_BITS];
  assign wr_tag = wr_pc_i[`XLEN-1:BTB_IDX_W+PC_ALIGN_BITS];

  // Hit needs a live entry whose tag matches the full upper PC
  // Aliased PCs with the same index but another tag miss here
  assign hit_o       = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign rd_target_o = target_q[rd_idx];

  // Valid bits
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `BTB_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (wr_en_i) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Tag and target payload
  // Whatever held this index before is simply replaced
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= wr_target_i;
    end
  end

endmodule

// File: design/core_pkg.sv
`include "frontend_defs.svh"

package core_pkg;

  // Byte address as seen by every pipeline stage
  typedef logic [`XLEN-1:0] pc_t;

  // Raw instruction word as delivered by fetch
  typedef logic [`ILEN-1:0] instr_t;

  // Byte distance between two sequential instructions
  localparam int unsigned PC_STEP = `ILEN / 8;

  // Number of always-zero low PC bits
  // Table indices start right above these
  localparam int unsigned PC_ALIGN_BITS = $clog2(PC_STEP);

endpackage

// File: design/frontend_defs.svh
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// Width of every address in the front end
`define XLEN 32

// Width of one instruction word
// No compressed instructions, so the PC always steps by ILEN/8 bytes
`define ILEN 32

// First fetch address after reset
// Sits above the low vector area of the boot ROM
`define BOOT_PC 32'h0000_0200

// Depth of the branch history table
// One two-bit counter per entry, must be a power of two
`define BHT_ENTRIES 64

// Depth of the branch target buffer
// Direct-mapped, must be a power of two
`define BTB_ENTRIES 16

// Table indices skip the two low PC bits
// Those are always zero for aligned 32-bit instructions

`endif

// File: design/frontend_top.sv
`timescale 1ns/1ps

module frontend_top
  import core_pkg::*;
  import bpu_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  // Exception redirect from commit
  input  logic        except_i,
  input  pc_t         except_pc_i,
  // Branch outcome from execute
  input  resolution_t res_i,
  // Fetch unit can take a new address
  input  logic        fetch_ready_i,
  output pc_t         pc_o
);

  // Prediction for the current PC
  prediction_t pred;

  // Looks up the PC currently held in the PC register
  branch_predictor i_branch_predictor (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .pc_i    (pc_o),
    .res_i   (res_i),
    .pred_o  (pred)
  );

  // Picks the next fetch address and holds the PC register
  pc_gen_stage i_pc_gen_stage (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .except_i      (except_i),
    .except_pc_i   (except_pc_i),
    .res_i         (res_i),
    .pred_i        (pred),
    .fetch_ready_i (fetch_ready_i),
    .pc_o          (pc_o)
  );

endmodule

// File: design/pc_gen_stage.sv
`timescale 1ns/1ps

`include "frontend_defs.svh"

module pc_gen_stage
  import core_pkg::*;
  import bpu_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        except_i,
  input  pc_t         except_pc_i,
  input  resolution_t res_i,
  input  prediction_t pred_i,
  input  logic        fetch_ready_i,
  output pc_t         pc_o
);

  logic res_redirect;
  pc_t  add_base;
  pc_t  seq_pc;
  pc_t  next_pc;

  // Execute caught a wrong path
  assign res_redirect = res_i.valid && res_i.mispredict;

  // Shared adder
  // On a not-taken misprediction restart right after the branch
  assign add_base = res_redirect ? res_i.pc : pc_o;
  assign seq_pc   = add_base + pc_t'(`ILEN / 8);

  // Next PC priority
  // Exception, then misprediction, then predicted taken, then sequential
  always_comb begin
    if (except_i) begin
      next_pc = except_pc_i;
    end else if (res_redirect) begin
      if (res_i.taken) begin
        next_pc = res_i.target;
      end else begin
        next_pc = seq_pc;
      end
    end else if (pred_i.taken) begin
      next_pc = pred_i.target;
    end else begin
      next_pc = seq_pc;
    end
  end

  // PC register
  // Holds while fetch cannot accept a new address
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_o <= `BOOT_PC;
    end else if (fetch_ready_i) begin
      pc_o <= next_pc;
    end
  end

endmodule

// File: src.f
+incdir+design
design/core_pkg.sv
design/bpu_pkg.sv
design/pc_gen_stage.sv
design/bht.sv
design/btb.sv
design/branch_predictor.sv
design/frontend_top.sv
test/tb_frontend.sv

// File: test/tb_frontend.sv
`timescale 1ns/1ps

`include "frontend_defs.svh"

module tb_frontend
  import core_pkg::*;
  import bpu_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DLY   = 2;
  // Sample point sits 2 ns before the next rising edge
  localparam int SAMPLE_DLY  = CLK_PERIOD - DRIVE_DLY - 2;
  localparam int RST_CYCLES  = 4;
  localparam int RST_TIMEOUT = 20;

  // One table row: stimulus for this cycle plus the values expected
  // at the PC register and the predictor before the next edge
  typedef struct packed {
    logic        exc;
    pc_t         exc_pc;
    resolution_t res;
    logic        ready;
    pc_t         exp_pc;
    logic        exp_taken;
  } row_t;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        except_i;
  pc_t         except_pc_i;
  resolution_t res_i;
  logic        fetch_ready_i;
  pc_t         pc_o;

  row_t  rows[$];
  string names[$];

  int pc_errs    = 0;
  int taken_errs = 0;
  int other_errs = 0;

  frontend_top i_dut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .except_i      (except_i),
    .except_pc_i   (except_pc_i),
    .res_i         (res_i),
    .fetch_ready_i (fetch_ready_i),
    .pc_o          (pc_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Reset held for a fixed number of cycles, released off the edge
  initial begin
    rst_n_i = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    rst_n_i = 1'b1;
  end

  // Full row with exception and resolution fields
  task automatic add_row(input string name, input logic exc, input pc_t exc_pc,
                         input logic v, input logic m, input logic t, input pc_t rpc,
                         input pc_t rtgt, input logic rdy, input pc_t epc,
                         input logic etk);
    row_t r;
    r.exc            = exc;
    r.exc_pc         = exc_pc;
    r.res.valid      = v;
    r.res.mispredict = m;
    r.res.taken      = t;
    r.res.pc         = rpc;
    r.res.target     = rtgt;
    r.ready          = rdy;
    r.exp_pc         = epc;
    r.exp_taken      = etk;
    rows.push_back(r);
    names.push_back(name);
  endtask

  // Quiet cycle, no redirect and no training
  task automatic add_step(input string name, input logic rdy, input pc_t epc,
                          input logic etk);
    add_row(name, 1'b0, '0, 1'b0, 1'b0, 1'b0, '0, '0, rdy, epc, etk);
  endtask

  task automatic build_table();
    // Expected PC of a row is what the previous row's inputs selected
    // Boot value, sequential step and stall
    add_step("boot_pc",       1'b1, `BOOT_PC,     1'b0);
    add_step("seq_step",      1'b1, 32'h0000_0204, 1'b0);
    add_step("stall_start",   1'b0, 32'h0000_0208, 1'b0);
    add_step("stall_hold",    1'b0, 32'h0000_0208, 1'b0);
    add_step("stall_release", 1'b1, 32'h0000_0208, 1'b0);
    // Exception together with a taken misprediction
    add_row("except_and_mispredict", 1'b1, 32'h0000_0100,
            1'b1, 1'b1, 1'b1, 32'h0000_0844, 32'h0000_0900,
            1'b1, 32'h0000_020c, 1'b0);
    // Exception PC wins, then a taken misprediction
    add_row("except_pc_loaded", 1'b0, '0,
            1'b1, 1'b1, 1'b1, 32'h0000_00a0, 32'h0000_1000,
            1'b1, 32'h0000_0100, 1'b0);
    // Not-taken misprediction restarts after the branch
    add_row("mispredict_target_loaded", 1'b0, '0,
            1'b1, 1'b1, 1'b0, 32'h0000_00c8, 32'h0000_2000,
            1'b1, 32'h0000_1000, 1'b0);
    // Branch A at 0xd8 resolves taken once, counter to WEAK_T
    add_row("mispredict_nt_loaded", 1'b0, '0,
            1'b1, 1'b0, 1'b1, 32'h0000_00d8, 32'h0000_3000,
            1'b1, 32'h0000_00cc, 1'b0);
    add_step("walk_to_a_0",   1'b1, 32'h0000_00d0, 1'b0);
    add_step("walk_to_a_1",   1'b1, 32'h0000_00d4, 1'b0);
    add_step("a_predicted",   1'b1, 32'h0000_00d8, 1'b1);
    // Two not-taken outcomes at A bring it down to STRONG_NT
    add_row("a_trained_target", 1'b0, '0,
            1'b1, 1'b0, 1'b0, 32'h0000_00d8, '0,
            1'b1, 32'h0000_3000, 1'b0);
    // Exception steers back before A while training goes on
    add_row("a_second_nt", 1'b1, 32'h0000_00d0,
            1'b1, 1'b0, 1'b0, 32'h0000_00d8, '0,
            1'b1, 32'h0000_3004, 1'b0);
    add_step("revisit_a_0",     1'b1, 32'h0000_00d0, 1'b0);
    add_step("revisit_a_1",     1'b1, 32'h0000_00d4, 1'b0);
    add_step("a_not_predicted", 1'b1, 32'h0000_00d8, 1'b0);
    // Alias A+64 pre-trained taken, then A reclaims the BTB entry
    add_row("a_fall_through", 1'b0, '0,
            1'b1, 1'b0, 1'b1, 32'h0000_0118, 32'h0000_5000,
            1'b1, 32'h0000_00dc, 1'b0);
    add_row("a_retrain_taken", 1'b1, 32'h0000_0114,
            1'b1, 1'b0, 1'b1, 32'h0000_00d8, 32'h0000_3000,
            1'b1, 32'h0000_00e0, 1'b0);
    add_step("before_alias",       1'b1, 32'h0000_0114, 1'b0);
    // Counter reads taken but the tag differs
    add_step("alias_no_pred",      1'b1, 32'h0000_0118, 1'b0);
    // Exception steers back to A once more
    add_row("alias_fall_through", 1'b1, 32'h0000_00d8,
            1'b0, 1'b0, 1'b0, '0, '0,
            1'b1, 32'h0000_011c, 1'b0);
    // One taken outcome from STRONG_NT only reaches WEAK_NT
    add_step("a_weak_nt_no_pred",      1'b1, 32'h0000_00d8, 1'b0);
    add_step("a_weak_nt_fall_through", 1'b1, 32'h0000_00dc, 1'b0);
  endtask

  task automatic check_pc(input string name, input pc_t exp_val, input pc_t act_val);
    if (act_val !== exp_val) begin
      pc_errs = pc_errs + 1;
      $display("** Error: %s pc_o expected %h actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic check_taken(input string name, input logic exp_val,
                             input logic act_val);
    if (act_val !== exp_val) begin
      taken_errs = taken_errs + 1;
      $display("** Error: %s pred.taken expected %b actual %b", name, exp_val, act_val);
    end
  endtask

  task automatic wait_reset_release(output logic released);
    int cycles;
    cycles = 0;
    while (rst_n_i !== 1'b1 && cycles < RST_TIMEOUT) begin
      @(posedge clk_i);
      cycles = cycles + 1;
    end
    released = (rst_n_i === 1'b1);
    if (!released) begin
      other_errs = other_errs + 1;
      $display("Reset was never released within %0d cycles", RST_TIMEOUT);
    end
  endtask

  task automatic apply_rows();
    row_t r;
    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      @(posedge clk_i);
      #DRIVE_DLY;
      except_i      = r.exc;
      except_pc_i   = r.exc_pc;
      res_i         = r.res;
      fetch_ready_i = r.ready;
      #SAMPLE_DLY;
      check_pc(names[i], r.exp_pc, pc_o);
      // Prediction is internal to the top, probed through the hierarchy
      check_taken(names[i], r.exp_taken, i_dut.pred.taken);
    end
  endtask

  task automatic finish_run();
    int total;
    total = pc_errs + taken_errs + other_errs;
    $display("Error counts: pc_o %0d, pred.taken %0d, other %0d, total %0d",
             pc_errs, taken_errs, other_errs, total);
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  initial begin : main_seq
    logic released;
    // Idle inputs, fetch stalled until the first row
    except_i      = 1'b0;
    except_pc_i   = '0;
    res_i         = '0;
    fetch_ready_i = 1'b0;
    build_table();
    wait_reset_release(released);
    if (released) begin
      apply_rows();
    end
    finish_run();
  end

endmodule
